/* common/adc_rx_settings.svh */
`ifndef ADC_RX_SETTINGS_SVH
`define ADC_RX_SETTINGS_SVH

// converter geometry, two data lanes per channel
`define ADC_LANES 8
`define ADC_CHANNELS 4

// serial bits per lane per frame period
`define ADC_WORD_BITS 8

// frame lane high for the first half of the word
`define ADC_FRAME_PATTERN 8'hF0

// matching frame words needed before lock
`define ADC_LOCK_COUNT 4

// words skipped after each bitslip
`define ADC_SLIP_WAIT 2

// register block, 0x0 to 0xC
`define ADC_AXI_ADDR_BITS 4

`endif

/* common/adc_rx_pkg.sv */
package adc_rx_pkg;

`include "adc_rx_settings.svh"

	// one deserialized lane word
	typedef logic [`ADC_WORD_BITS-1:0] lane_word_t;

	// per-lane bit, bit i is lane i
	typedef logic [`ADC_LANES-1:0] lane_mask_t;

	// one channel sample, both lanes interleaved
	typedef logic [2*`ADC_WORD_BITS-1:0] adc_sample_t;

	// slips issued, saturates
	typedef logic [7:0] slip_count_t;

	// deserializer output, frame word rides along for alignment
	typedef struct packed {
		lane_word_t [`ADC_LANES-1:0] lanes;
		lane_word_t frame;
		logic valid;
	} deser_words_t;

	// data words after the frame check
	typedef struct packed {
		lane_word_t [`ADC_LANES-1:0] lanes;
		logic valid;
		logic locked;
	} aligned_words_t;

	// index c holds channel c
	typedef struct packed {
		adc_sample_t [`ADC_CHANNELS-1:0] sample;
		logic valid;
	} sample_set_t;

	// word boundary search
	typedef enum logic [1:0] {
		SEARCH,
		WAIT,
		LOCKED
	} align_state_t;

endpackage

/* src/lane_deser.sv */
`timescale 1ns/1ps

`include "adc_rx_settings.svh"

module lane_deser (
	input logic clk_div,
	input logic rst_n,
	input adc_rx_pkg::lane_mask_t lane_in,
	input logic frame_in,
	input logic slip,
	output adc_rx_pkg::deser_words_t words
);

	import adc_rx_pkg::*;

	// one shift register per data lane plus the frame lane
	lane_word_t lane_sr [`ADC_LANES];
	lane_word_t frame_sr;

	// bit position inside the current word
	logic [2:0] phase;
	logic emit;
	logic valid_q;

	// newest bit enters at the lsb, so the oldest ends up as msb
	always_ff @(posedge clk_div) begin
		for (int i = 0; i < `ADC_LANES; i++) begin
			lane_sr[i] <= {lane_sr[i][`ADC_WORD_BITS-2:0], lane_in[i]};
		end
		frame_sr <= {frame_sr[`ADC_WORD_BITS-2:0], frame_in};
	end

	// word complete once this cycle's bit goes in
	// a slip cycle stalls the count, boundary moves one bit later
	assign emit = (phase == 3'(`ADC_WORD_BITS - 1)) && !slip;

	always_ff @(posedge clk_div) begin
		if (!rst_n) begin
			phase <= '0;
			valid_q <= 1'b0;
		end else begin
			if (!slip) begin
				phase <= phase + 3'd1;
			end
			valid_q <= emit;
		end
	end

	// shift registers hold the finished word during the valid cycle
	always_comb begin
		for (int i = 0; i < `ADC_LANES; i++) begin
			words.lanes[i] = lane_sr[i];
		end
		words.frame = frame_sr;
		words.valid = valid_q;
	end

endmodule

/* src/frame_align.sv */
`timescale 1ns/1ps

`include "adc_rx_settings.svh"

module frame_align (
	input logic clk_div,
	input logic rst_n,
	input adc_rx_pkg::deser_words_t words,
	input logic align_en,
	input logic manual_slip,
	output logic slip,
	output adc_rx_pkg::aligned_words_t aligned,
	output adc_rx_pkg::slip_count_t slip_count,
	output adc_rx_pkg::lane_word_t last_frame
);

	import adc_rx_pkg::*;

	align_state_t state, state_nx;
	logic [2:0] match_cnt, match_nx;
	logic [1:0] wait_cnt, wait_nx;
	logic frame_ok;
	logic auto_slip;
	logic slip_nx;
	lane_word_t [`ADC_LANES-1:0] lanes_q;
	logic valid_q;

	assign frame_ok = (words.frame == lane_word_t'(`ADC_FRAME_PATTERN));

	always_comb begin
		state_nx = state;
		match_nx = match_cnt;
		wait_nx = wait_cnt;
		auto_slip = 1'b0;
		if (words.valid) begin
			case (state)
				SEARCH: begin
					if (frame_ok) begin
						match_nx = match_cnt + 3'd1;
						if (match_cnt == 3'(`ADC_LOCK_COUNT - 1)) begin
							state_nx = LOCKED;
						end
					end else begin
						// count restarts, slip only when auto mode is on
						match_nx = '0;
						auto_slip = align_en;
					end
				end
				WAIT: begin
					wait_nx = wait_cnt + 2'd1;
					if (wait_cnt == 2'(`ADC_SLIP_WAIT - 1)) begin
						state_nx = SEARCH;
						wait_nx = '0;
					end
				end
				LOCKED: begin
					// drop lock, this word is not slipped
					if (!frame_ok) begin
						state_nx = SEARCH;
						match_nx = '0;
					end
				end
				default: state_nx = SEARCH;
			endcase
		end
		// manual requests share the pulse, never two cycles in a row
		slip_nx = (auto_slip | manual_slip) & ~slip;
		if (slip_nx) begin
			state_nx = WAIT;
			match_nx = '0;
			wait_nx = '0;
		end
	end

	always_ff @(posedge clk_div) begin
		if (!rst_n) begin
			state <= SEARCH;
			match_cnt <= '0;
			wait_cnt <= '0;
			slip <= 1'b0;
			valid_q <= 1'b0;
			slip_count <= '0;
			last_frame <= '0;
		end else begin
			state <= state_nx;
			match_cnt <= match_nx;
			wait_cnt <= wait_nx;
			slip <= slip_nx;
			valid_q <= words.valid;
			// saturating count of every pulse issued
			if (slip_nx && slip_count != '1) begin
				slip_count <= slip_count + 8'd1;
			end
			if (words.valid) begin
				last_frame <= words.frame;
			end
		end
	end

	always_ff @(posedge clk_div) begin
		lanes_q <= words.lanes;
	end

	// locked is the state just entered, so the word that breaks lock goes out unlocked
	assign aligned = '{lanes: lanes_q, valid: valid_q, locked: (state == LOCKED)};

endmodule

/* src/sample_pack.sv */
`timescale 1ns/1ps

`include "adc_rx_settings.svh"

module sample_pack (
	input logic clk_div,
	input logic rst_n,
	input adc_rx_pkg::aligned_words_t aligned,
	input adc_rx_pkg::lane_mask_t flip_mask,
	output adc_rx_pkg::sample_set_t samples
);

	import adc_rx_pkg::*;

	lane_word_t [`ADC_LANES-1:0] fixed;
	adc_sample_t [`ADC_CHANNELS-1:0] packed_d;
	adc_sample_t [`ADC_CHANNELS-1:0] sample_q;
	logic valid_q;

	// undo board level polarity swaps
	always_comb begin
		for (int i = 0; i < `ADC_LANES; i++) begin
			fixed[i] = aligned.lanes[i] ^ {`ADC_WORD_BITS{flip_mask[i]}};
		end
	end

	// lane 2c carries even sample bits, lane 2c+1 the odd ones
	always_comb begin
		for (int c = 0; c < `ADC_CHANNELS; c++) begin
			for (int k = 0; k < `ADC_WORD_BITS; k++) begin
				packed_d[c][2*k+1] = fixed[2*c+1][k];
				packed_d[c][2*k] = fixed[2*c][k];
			end
		end
	end

	always_ff @(posedge clk_div) begin
		if (!rst_n) begin
			valid_q <= 1'b0;
		end else begin
			// nothing leaves before the frame has locked
			valid_q <= aligned.valid & aligned.locked;
		end
	end

	always_ff @(posedge clk_div) begin
		sample_q <= packed_d;
	end

	assign samples = '{sample: sample_q, valid: valid_q};

endmodule

/* src/adc_csr.sv */
`timescale 1ns/1ps

`include "adc_rx_settings.svh"

module adc_csr (
	input logic clk_div,
	input logic rst_n,
	// write address and data
	input logic [`ADC_AXI_ADDR_BITS-1:0] s_awaddr,
	input logic s_awvalid,
	output logic s_awready,
	input logic [31:0] s_wdata,
	input logic [3:0] s_wstrb,
	input logic s_wvalid,
	output logic s_wready,
	// write response
	output logic [1:0] s_bresp,
	output logic s_bvalid,
	input logic s_bready,
	// read
	input logic [`ADC_AXI_ADDR_BITS-1:0] s_araddr,
	input logic s_arvalid,
	output logic s_arready,
	output logic [31:0] s_rdata,
	output logic [1:0] s_rresp,
	output logic s_rvalid,
	input logic s_rready,
	// alignment control and status
	output logic align_en,
	output logic manual_slip,
	output adc_rx_pkg::lane_mask_t flip_mask,
	input logic locked,
	input adc_rx_pkg::slip_count_t slip_count,
	input adc_rx_pkg::lane_word_t last_frame
);

	logic wr_hs;
	logic rd_hs;
	logic wr_map;
	logic rd_map;
	logic [31:0] rd_word;

	// aw and w taken together, only while no response waits
	assign s_awready = s_awvalid & s_wvalid & ~s_bvalid;
	assign s_wready = s_awready;
	assign wr_hs = s_awready;

	assign s_arready = ~s_rvalid;
	assign rd_hs = s_arvalid & s_arready;

	// registers sit on word addresses
	assign wr_map = (s_awaddr[1:0] == 2'b00);

	always_comb begin
		rd_map = 1'b1;
		case (s_araddr)
			'h0: rd_word = {30'b0, 1'b0, align_en};
			'h4: rd_word = {24'b0, flip_mask};
			'h8: rd_word = {16'b0, slip_count, 7'b0, locked};
			'hC: rd_word = {24'b0, last_frame};
			default: begin
				rd_word = '0;
				rd_map = 1'b0;
			end
		endcase
	end

	always_ff @(posedge clk_div) begin
		if (!rst_n) begin
			align_en <= 1'b1;
			manual_slip <= 1'b0;
			flip_mask <= '0;
		end else begin
			// slip request is a single cycle pulse
			manual_slip <= 1'b0;
			if (wr_hs && wr_map && s_wstrb[0]) begin
				case (s_awaddr)
					'h0: begin
						align_en <= s_wdata[0];
						manual_slip <= s_wdata[1];
					end
					'h4: flip_mask <= s_wdata[7:0];
					default: ;
				endcase
			end
		end
	end

	// responses hold until taken
	always_ff @(posedge clk_div) begin
		if (!rst_n) begin
			s_bvalid <= 1'b0;
			s_rvalid <= 1'b0;
		end else begin
			if (wr_hs) begin
				s_bvalid <= 1'b1;
			end else if (s_bready) begin
				s_bvalid <= 1'b0;
			end
			if (rd_hs) begin
				s_rvalid <= 1'b1;
			end else if (s_rready) begin
				s_rvalid <= 1'b0;
			end
		end
	end

	// okay or slverr, data frozen while rvalid is up
	always_ff @(posedge clk_div) begin
		if (wr_hs) begin
			s_bresp <= wr_map ? 2'b00 : 2'b10;
		end
		if (rd_hs) begin
			s_rdata <= rd_word;
			s_rresp <= rd_map ? 2'b00 : 2'b10;
		end
	end

endmodule

/* src/adc_rx_top.sv */
`timescale 1ns/1ps

`include "adc_rx_settings.svh"

module adc_rx_top (
	input logic clk_div,
	input logic rst_n,
	input adc_rx_pkg::lane_mask_t lane_in,
	input logic frame_in,
	input logic [`ADC_AXI_ADDR_BITS-1:0] s_awaddr,
	input logic s_awvalid,
	output logic s_awready,
	input logic [31:0] s_wdata,
	input logic [3:0] s_wstrb,
	input logic s_wvalid,
	output logic s_wready,
	output logic [1:0] s_bresp,
	output logic s_bvalid,
	input logic s_bready,
	input logic [`ADC_AXI_ADDR_BITS-1:0] s_araddr,
	input logic s_arvalid,
	output logic s_arready,
	output logic [31:0] s_rdata,
	output logic [1:0] s_rresp,
	output logic s_rvalid,
	input logic s_rready,
	output adc_rx_pkg::sample_set_t samples
);

	import adc_rx_pkg::*;

	deser_words_t deser;
	aligned_words_t aligned;
	logic slip;
	logic align_en;
	logic manual_slip;
	lane_mask_t flip_mask;
	slip_count_t slip_count;
	lane_word_t last_frame;

	// bits in, words every eight cycles
	lane_deser u_deser (
		.clk_div(clk_div),
		.rst_n(rst_n),
		.lane_in(lane_in),
		.frame_in(frame_in),
		.slip(slip),
		.words(deser)
	);

	// slip feeds back into the deserializer phase
	frame_align u_align (
		.clk_div(clk_div),
		.rst_n(rst_n),
		.words(deser),
		.align_en(align_en),
		.manual_slip(manual_slip),
		.slip(slip),
		.aligned(aligned),
		.slip_count(slip_count),
		.last_frame(last_frame)
	);

	sample_pack u_pack (
		.clk_div(clk_div),
		.rst_n(rst_n),
		.aligned(aligned),
		.flip_mask(flip_mask),
		.samples(samples)
	);

	// locked comes straight off the aligned word struct
	adc_csr u_csr (
		.clk_div(clk_div),
		.rst_n(rst_n),
		.s_awaddr(s_awaddr),
		.s_awvalid(s_awvalid),
		.s_awready(s_awready),
		.s_wdata(s_wdata),
		.s_wstrb(s_wstrb),
		.s_wvalid(s_wvalid),
		.s_wready(s_wready),
		.s_bresp(s_bresp),
		.s_bvalid(s_bvalid),
		.s_bready(s_bready),
		.s_araddr(s_araddr),
		.s_arvalid(s_arvalid),
		.s_arready(s_arready),
		.s_rdata(s_rdata),
		.s_rresp(s_rresp),
		.s_rvalid(s_rvalid),
		.s_rready(s_rready),
		.align_en(align_en),
		.manual_slip(manual_slip),
		.flip_mask(flip_mask),
		.locked(aligned.locked),
		.slip_count(slip_count),
		.last_frame(last_frame)
	);

endmodule

/* dv/adc_rx_asserts.sv */
`timescale 1ns/1ps

module adc_rx_asserts (
	input logic clk_div,
	input logic rst_n,
	input logic s_bvalid,
	input logic s_bready,
	input logic s_rvalid,
	input logic s_rready,
	input logic [31:0] s_rdata,
	input logic slip,
	input logic locked,
	input logic sample_valid
);

	// write response waits for bready
	bresp_hold: assert property (@(posedge clk_div) disable iff (!rst_n)
		s_bvalid && !s_bready |=> s_bvalid)
		else $error("bvalid dropped before bready");

	// read response and its data wait for rready
	rresp_hold: assert property (@(posedge clk_div) disable iff (!rst_n)
		s_rvalid && !s_rready |=> s_rvalid && $stable(s_rdata))
		else $error("rvalid or rdata changed before rready");

	// bitslip is a single cycle pulse
	slip_pulse: assert property (@(posedge clk_div) disable iff (!rst_n)
		slip |=> !slip)
		else $error("slip high for two cycles");

	// sample set built from a locked word only
	valid_locked: assert property (@(posedge clk_div) disable iff (!rst_n)
		sample_valid |-> $past(locked))
		else $error("sample set valid without lock");

endmodule

bind adc_rx_top adc_rx_asserts u_asserts (
	.clk_div(clk_div),
	.rst_n(rst_n),
	.s_bvalid(s_bvalid),
	.s_bready(s_bready),
	.s_rvalid(s_rvalid),
	.s_rready(s_rready),
	.s_rdata(s_rdata),
	.slip(slip),
	.locked(aligned.locked),
	.sample_valid(samples.valid)
);

/* dv/adc_rx_tb.sv */
`timescale 1ns/1ps

`include "adc_rx_settings.svh"

module adc_rx_tb;

	import adc_rx_pkg::*;

	localparam int ROWS = 6;
	// misalign, model flip, flip register, auto mode, sample sets
	localparam int ROW_MIS [ROWS] = '{3, 5, 0, 2, 1, 7};
	localparam logic [7:0] ROW_MFLIP [ROWS] = '{8'h00, 8'hA5, 8'hA5, 8'h00, 8'h00, 8'h0F};
	localparam logic [7:0] ROW_CFLIP [ROWS] = '{8'h00, 8'hA5, 8'h3C, 8'h00, 8'h00, 8'h0F};
	localparam logic ROW_AUTO [ROWS] = '{1'b1, 1'b1, 1'b1, 1'b0, 1'b1, 1'b1};
	localparam int ROW_SETS [ROWS] = '{40, 40, 30, 30, 30, 30};
	localparam lane_word_t FRAME_WORD = `ADC_FRAME_PATTERN;

	logic clk_div = 1'b0;
	logic rst_n = 1'b0;
	lane_mask_t lane_in = '0;
	logic frame_in = 1'b0;
	logic [3:0] s_awaddr = '0;
	logic s_awvalid = 1'b0;
	logic s_awready;
	logic [31:0] s_wdata = '0;
	logic [3:0] s_wstrb = '0;
	logic s_wvalid = 1'b0;
	logic s_wready;
	logic [1:0] s_bresp;
	logic s_bvalid;
	logic s_bready = 1'b0;
	logic [3:0] s_araddr = '0;
	logic s_arvalid = 1'b0;
	logic s_arready;
	logic [31:0] s_rdata;
	logic [1:0] s_rresp;
	logic s_rvalid;
	logic s_rready = 1'b0;
	sample_set_t samples;

	// serial model state
	logic [15:0] lfsr_state = 16'd25;
	logic [63:0] cur_set = '0;
	int bit_idx = 0;
	int jump_req = 0;
	lane_mask_t model_flip = '0;
	lane_mask_t csr_flip = '0;
	logic rst_seen;
	// expected sample sets with the cycle they should leave
	int due_q[$];
	logic [63:0] exp_q[$];
	lane_mask_t flip_q[$];
	int cycle = 0;
	int limit = 0;
	int fail_count = 0;
	logic steady = 1'b0;
	int steady_from = 0;
	int no_valid_from = 0;
	int no_valid_until = 0;
	int exp_slips = 0;
	logic [31:0] rd;
	logic [1:0] resp;

	adc_rx_top uut (.*);

	always #4 clk_div = ~clk_div;

	always @(posedge clk_div) begin
		cycle <= cycle + 1;
		if (limit != 0 && cycle > limit) begin
			$display("ERROR: run did not finish within %0d cycles", limit);
			$display("Simulation finished: FAIL");
			$fatal(1);
		end
	end

	function logic next_lfsr_bit();
		logic out;
		out = lfsr_state[0];
		lfsr_state = (lfsr_state >> 1) ^ (out ? 16'hB400 : 16'h0000);
		return out;
	endfunction

	// lane 2c holds even sample bits, lane 2c+1 odd ones
	function automatic logic [63:0] lane_spread(lane_mask_t m);
		logic [63:0] s;
		for (int c = 0; c < 4; c++) begin
			for (int k = 0; k < 8; k++) begin
				s[16*c+2*k] = m[2*c];
				s[16*c+2*k+1] = m[2*c+1];
			end
		end
		return s;
	endfunction

	task automatic check(string name, logic [63:0] got, logic [63:0] exp);
		if (got !== exp) begin
			fail_count++;
			$display("[FAIL] %s got %h expected %h", name, got, exp);
			$display("Simulation finished: FAIL");
			$fatal(1);
		end
	endtask

	task automatic stop_run(string why);
		fail_count++;
		$display("ERROR: %s", why);
		$display("Simulation finished: FAIL");
		$fatal(1);
	endtask

	// serial lane model, msb first, word restarts while reset is seen
	always @(posedge clk_div) begin
		rst_seen = rst_n;
		#1;
		if (!rst_seen) begin
			bit_idx = 0;
		end
		// jump only at a word start, so the whole next word is shifted
		if (jump_req != 0 && bit_idx == 0) begin
			bit_idx = jump_req;
			jump_req = 0;
			// last good set leaves at +2, the shifted one must not be valid
			no_valid_from = cycle + 3;
			no_valid_until = cycle + 11;
		end
		if (bit_idx == 0) begin
			for (int i = 0; i < 64; i++) begin
				cur_set[i] = next_lfsr_bit();
			end
		end
		for (int c = 0; c < 4; c++) begin
			lane_in[2*c] = cur_set[16*c+2*(7-bit_idx)] ^ model_flip[2*c];
			lane_in[2*c+1] = cur_set[16*c+2*(7-bit_idx)+1] ^ model_flip[2*c+1];
		end
		frame_in = FRAME_WORD[7 - bit_idx];
		if (bit_idx == 7 && rst_seen) begin
			due_q.push_back(cycle + 3);
			exp_q.push_back(cur_set);
			flip_q.push_back(model_flip);
		end
		bit_idx = (bit_idx + 1) % 8;
	end

	// sample monitor, in order and without gaps while steady
	always @(negedge clk_div) begin
		if (rst_n) begin
			while (due_q.size() > 0 && due_q[0] < cycle) begin
				if (steady && due_q[0] >= steady_from) begin
					stop_run("sample set missing while locked");
				end
				void'(due_q.pop_front());
				void'(exp_q.pop_front());
				void'(flip_q.pop_front());
			end
			if (samples.valid && cycle >= no_valid_from && cycle < no_valid_until) begin
				stop_run("sample set valid right after the frame moved");
			end
			if (due_q.size() > 0 && due_q[0] == cycle) begin
				if (steady) begin
					if (!samples.valid) begin
						stop_run("sample set not valid while locked");
					end
					check("samples", samples.sample,
						exp_q[0] ^ lane_spread(flip_q[0] ^ csr_flip));
				end
				void'(due_q.pop_front());
				void'(exp_q.pop_front());
				void'(flip_q.pop_front());
			end else if (steady && samples.valid) begin
				stop_run("valid sample set with no word sent");
			end
		end
	end

	task automatic axi_write(input logic [3:0] addr, input logic [31:0] data, input int hold,
		output logic [1:0] bresp);
		@(posedge clk_div);
		#1;
		s_awaddr = addr;
		s_wdata = data;
		s_wstrb = 4'hF;
		s_awvalid = 1'b1;
		s_wvalid = 1'b1;
		s_bready = (hold == 0);
		do @(negedge clk_div); while (!s_awready);
		check("s_wready", s_wready, 1'b1);
		@(posedge clk_div);
		#1;
		s_awvalid = 1'b0;
		s_wvalid = 1'b0;
		@(negedge clk_div);
		while (!s_bvalid) @(negedge clk_div);
		bresp = s_bresp;
		repeat (hold) begin
			@(negedge clk_div);
			if (!s_bvalid) begin
				stop_run("bvalid dropped while bready was low");
			end
			check("s_bresp", s_bresp, bresp);
		end
		if (!s_bready) begin
			@(posedge clk_div);
			#1;
			s_bready = 1'b1;
		end
		@(posedge clk_div);
		#1;
		s_bready = 1'b0;
	endtask

	task automatic axi_read(input logic [3:0] addr, input int hold,
		output logic [31:0] data, output logic [1:0] rresp);
		@(posedge clk_div);
		#1;
		s_araddr = addr;
		s_arvalid = 1'b1;
		s_rready = (hold == 0);
		do @(negedge clk_div); while (!s_arready);
		@(posedge clk_div);
		#1;
		s_arvalid = 1'b0;
		@(negedge clk_div);
		while (!s_rvalid) @(negedge clk_div);
		data = s_rdata;
		rresp = s_rresp;
		repeat (hold) begin
			@(negedge clk_div);
			if (!s_rvalid) begin
				stop_run("rvalid dropped while rready was low");
			end
			check("s_rdata", s_rdata, data);
		end
		if (!s_rready) begin
			@(posedge clk_div);
			#1;
			s_rready = 1'b1;
		end
		@(posedge clk_div);
		#1;
		s_rready = 1'b0;
	endtask

	task automatic wait_lock();
		do axi_read(4'h8, 0, rd, resp); while (!rd[0]);
	endtask

	task automatic run_row(input int i);
		int m;
		m = ROW_MIS[i];
		steady = 1'b0;
		axi_write(4'h0, {31'b0, ROW_AUTO[i]}, 0, resp);
		check("ctrl bresp", resp, 2'b00);
		axi_write(4'h4, {24'b0, ROW_CFLIP[i]}, 0, resp);
		check("flip bresp", resp, 2'b00);
		csr_flip = ROW_CFLIP[i];
		axi_read(4'h4, 0, rd, resp);
		check("flip", rd, {24'b0, ROW_CFLIP[i]});
		axi_read(4'h0, 0, rd, resp);
		check("ctrl", rd, {31'b0, ROW_AUTO[i]});
		@(negedge clk_div);
		model_flip = ROW_MFLIP[i];
		if (m != 0) begin
			// stream moves 8-m bits ahead, m later slips undo it
			jump_req = (8 - m) % 8;
			repeat (16) @(negedge clk_div);
			axi_read(4'h8, 0, rd, resp);
			check("status locked", rd[0], 1'b0);
		end
		if (!ROW_AUTO[i]) begin
			for (int j = 0; j < m; j++) begin
				axi_read(4'h8, 0, rd, resp);
				check("status locked", rd[0], 1'b0);
				axi_write(4'h0, 32'h2, 0, resp);
				// slip request bit never reads back
				axi_read(4'h0, 0, rd, resp);
				check("ctrl", rd, 32'h0);
				repeat (4) @(negedge clk_div);
				axi_read(4'h8, 0, rd, resp);
				check("status slips", rd[15:8], 8'(exp_slips + j + 1));
				repeat (24) @(negedge clk_div);
			end
		end
		wait_lock();
		exp_slips += m;
		axi_read(4'h8, 0, rd, resp);
		check("status slips", rd[15:8], 8'(exp_slips));
		axi_read(4'hC, 0, rd, resp);
		check("frame", rd, 32'hF0);
		if (!ROW_AUTO[i]) begin
			axi_write(4'h0, 32'h1, 0, resp);
		end
		repeat (24) @(negedge clk_div);
		steady_from = cycle;
		steady = 1'b1;
		repeat (ROW_SETS[i] * 8) @(negedge clk_div);
		steady = 1'b0;
	endtask

	initial begin
		int lim;
		lim = 1000;
		for (int i = 0; i < ROWS; i++) begin
			lim += (ROW_MIS[i] + 8) * 3 * 8 + ROW_SETS[i] * 8 + 400;
		end
		limit = lim;
		repeat (2) @(posedge clk_div);
		#1;
		rst_n = 1'b1;
		// reset values, then first lock needs no slip
		axi_read(4'h0, 0, rd, resp);
		check("ctrl", rd, 32'h1);
		check("ctrl rresp", resp, 2'b00);
		axi_read(4'h4, 0, rd, resp);
		check("flip", rd, 32'h0);
		check("flip rresp", resp, 2'b00);
		wait_lock();
		axi_read(4'h8, 2, rd, resp);
		check("status", rd, 32'h1);
		check("status rresp", resp, 2'b00);
		axi_read(4'hC, 0, rd, resp);
		check("frame", rd, 32'hF0);
		check("frame rresp", resp, 2'b00);
		// unmapped address on both channels
		axi_write(4'h2, 32'hFFFF_FFFE, 3, resp);
		check("unmapped bresp", resp, 2'b10);
		axi_read(4'h2, 0, rd, resp);
		check("unmapped rresp", resp, 2'b10);
		axi_read(4'h0, 0, rd, resp);
		check("ctrl", rd, 32'h1);
		axi_read(4'h4, 0, rd, resp);
		check("flip", rd, 32'h0);
		for (int i = 0; i < ROWS; i++) begin
			run_row(i);
		end
		if (fail_count == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

/* project.f */
+incdir+common
common/adc_rx_pkg.sv
src/lane_deser.sv
src/frame_align.sv
src/sample_pack.sv
src/adc_csr.sv
src/adc_rx_top.sv
dv/adc_rx_asserts.sv
dv/adc_rx_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module adc_rx_tb -f project.f -o adc_rx_sim

./obj_dir/adc_rx_sim 2>&1 | tee sim.log

if grep -q "Simulation finished: PASS" sim.log; then
	exit 0
fi
exit 1
